//--- logic/csum_pkg.sv
`default_nettype none

package csum_pkg;

    typedef logic [15:0] word_t;

    // one record per block, fits a single APB read word
    typedef struct packed {
        logic [7:0] seq;    // block number, wraps
        logic [7:0] kernel;
        word_t      sum;    // modulo 2^16
    } csum_rec_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    localparam logic [3:0] ADDR_CTRL    = 4'h0;
    localparam logic [3:0] ADDR_STATUS  = 4'h4;
    localparam logic [3:0] ADDR_RESULT  = 4'h8;
    localparam logic [7:0] KERNEL_RESET = 8'd4;

endpackage

`default_nettype wire

//--- logic/sample_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sample_fifo #(
    parameter type payload_t = logic [15:0],
    parameter int  DEPTH     = 16,
    localparam int LEVEL_W   = $clog2(DEPTH + 1)
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 push,
    input  wire payload_t       push_data,
    output logic                full,
    input  wire                 pop,
    output payload_t            pop_data,
    output logic                empty,
    output logic [LEVEL_W-1:0]  level
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t           mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [LEVEL_W-1:0] count;
    logic               do_push;
    logic               do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(DEPTH - 1)) begin
            next_ptr = '0;  // depth need not be a power of two
        end else begin
            next_ptr = p + PTR_W'(1);
        end
    endfunction

    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign full     = (count == LEVEL_W'(DEPTH));
    assign empty    = (count == '0);
    assign level    = count;
    assign pop_data = mem[rd_ptr];  // first word falls through

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop) rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + LEVEL_W'(1);
                2'b01:   count <= count - LEVEL_W'(1);
                default: count <= count;  // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst) !(push && full));
    a_no_underflow: assert property (@(posedge clk) disable iff (rst) !(pop && empty));

endmodule

`default_nettype wire

//--- logic/accum_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module accum_pipe (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 op_valid,
    input  wire csum_pkg::word_t operand_a,
    input  wire csum_pkg::word_t operand_b,
    output logic                op_accept,
    output csum_pkg::word_t     result,
    output logic                result_rdy
);

    csum_pkg::word_t s1_a;
    csum_pkg::word_t s1_b;
    logic            s1_valid;

    assign op_accept = 1'b1;  // no stall condition

    //////////////////////////////////////////////////
    // stage 1 operand capture, stage 2 sum
    //////////////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid   <= 1'b0;
            result_rdy <= 1'b0;
        end else begin
            s1_valid   <= op_valid;
            result_rdy <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid) begin
            s1_a <= operand_a;
            s1_b <= operand_b;
        end
        if (s1_valid) result <= s1_a + s1_b;  // carry out dropped
    end

endmodule

`default_nettype wire

//--- logic/csum_engine.sv
`timescale 1ns/1ps
`default_nettype none

module csum_engine (
    input  wire                     clk,
    input  wire                     rst,
    input  wire [7:0]               kernel_size,
    input  wire csum_pkg::word_t    sample_data,
    input  wire                     sample_empty,
    output logic                    sample_pop,
    output logic                    acc_valid,
    output csum_pkg::word_t         acc_a,
    output csum_pkg::word_t         acc_b,
    input  wire csum_pkg::word_t    acc_result,
    input  wire                     acc_rdy,
    input  wire                     rec_full,
    output logic                    rec_push,
    output csum_pkg::csum_rec_t     rec_data
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_FLUSH
    } state_t;

    state_t          state;
    logic [7:0]      kernel_q;
    logic [7:0]      count;     // samples issued in this block
    logic            pending;   // one addition in flight
    logic [7:0]      seq_q;
    csum_pkg::word_t sum_q;

    //////////////////////////////////////////////////
    // sample pop and accumulator feed
    //////////////////////////////////////////////////
    assign sample_pop = (state == ST_BUSY) && !pending && !sample_empty
                        && (count != kernel_q);
    assign acc_valid  = sample_pop;
    assign acc_a      = (count == 8'd0) ? '0 : sum_q;  // first sample starts from zero
    assign acc_b      = sample_data;

    assign rec_push = (state == ST_FLUSH) && !rec_full;

    always_comb begin
        rec_data.seq    = seq_q;
        rec_data.kernel = kernel_q;
        rec_data.sum    = sum_q;
    end

    //////////////////////////////////////////////////
    // block sequencing
    //////////////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= ST_IDLE;
            kernel_q <= csum_pkg::KERNEL_RESET;
            count    <= 8'd0;
            pending  <= 1'b0;
            seq_q    <= 8'd0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (!sample_empty) begin
                        kernel_q <= kernel_size;  // held for the whole block
                        count    <= 8'd0;
                        state    <= ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    if (sample_pop) begin
                        count   <= count + 8'd1;
                        pending <= 1'b1;
                    end
                    if (acc_rdy) begin
                        pending <= 1'b0;
                        if (count == kernel_q) state <= ST_FLUSH;
                    end
                end
                ST_FLUSH: begin
                    // wait here while the result FIFO is full
                    if (rec_push) begin
                        seq_q <= seq_q + 8'd1;
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (acc_rdy) sum_q <= acc_result;  // partial sum
    end

    a_kernel_nonzero: assert property (@(posedge clk) disable iff (rst)
        (state != ST_IDLE) |-> (kernel_q != 8'd0));

endmodule

`default_nettype wire

//--- logic/csum_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module csum_apb_regs (
    input  wire                         clk,
    input  wire                         rst,
    input  wire csum_pkg::apb_req_t     apb_req,
    output csum_pkg::apb_rsp_t          apb_rsp,
    output logic [7:0]                  kernel_size,
    input  wire [7:0]                   sample_level,
    input  wire [7:0]                   rec_level,
    input  wire csum_pkg::csum_rec_t    rec_data,
    input  wire                         rec_empty,
    output logic                        rec_pop
);

    logic       access;
    logic       wr;
    logic       rd;
    logic [7:0] kernel_q;

    assign access      = apb_req.psel && apb_req.penable;
    assign wr          = access && apb_req.pwrite;
    assign rd          = access && !apb_req.pwrite;
    assign kernel_size = kernel_q;

    // pop in the same cycle the record is returned
    assign rec_pop = rd && (apb_req.paddr == csum_pkg::ADDR_RESULT) && !rec_empty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            kernel_q <= csum_pkg::KERNEL_RESET;
        end else if (wr && apb_req.paddr == csum_pkg::ADDR_CTRL
                     && apb_req.pwdata[7:0] != 8'd0) begin
            kernel_q <= apb_req.pwdata[7:0];
        end
    end

    //////////////////////////////////////////////////
    // read data and error response
    //////////////////////////////////////////////////
    always_comb begin
        apb_rsp.prdata  = 32'h0;
        apb_rsp.pready  = 1'b1;  // no wait states
        apb_rsp.pslverr = 1'b0;
        if (access) begin
            case (apb_req.paddr)
                csum_pkg::ADDR_CTRL: begin
                    if (apb_req.pwrite) apb_rsp.pslverr = (apb_req.pwdata[7:0] == 8'd0);
                    else apb_rsp.prdata = {24'h0, kernel_q};
                end
                csum_pkg::ADDR_STATUS: begin
                    if (apb_req.pwrite) apb_rsp.pslverr = 1'b1;  // read only
                    else apb_rsp.prdata = {16'h0, rec_level, sample_level};
                end
                csum_pkg::ADDR_RESULT: begin
                    if (apb_req.pwrite || rec_empty) apb_rsp.pslverr = 1'b1;
                    else apb_rsp.prdata = rec_data;
                end
                default: apb_rsp.pslverr = 1'b1;
            endcase
        end
    end

    // a pop must follow a setup phase on the previous edge
    a_pop_in_access: assert property (@(posedge clk) disable iff (rst)
        rec_pop |-> $past(apb_req.psel && !apb_req.penable));

endmodule

`default_nettype wire

//--- logic/csum_top.sv
`timescale 1ns/1ps
`default_nettype none

module csum_top #(
    parameter int SAMPLE_DEPTH = 16,
    parameter int RESULT_DEPTH = 4
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     in_valid,
    input  wire csum_pkg::word_t    in_data,
    output logic                    in_ready,
    input  wire csum_pkg::apb_req_t apb_req,
    output csum_pkg::apb_rsp_t      apb_rsp
);

    localparam int SAMPLE_LW = $clog2(SAMPLE_DEPTH + 1);
    localparam int RESULT_LW = $clog2(RESULT_DEPTH + 1);

    logic                   sample_full;
    logic                   sample_pop;
    logic                   sample_empty;
    csum_pkg::word_t        sample_data;
    logic [SAMPLE_LW-1:0]   sample_level;

    logic                   rec_push;
    csum_pkg::csum_rec_t    rec_in;
    logic                   rec_full;
    logic                   rec_pop;
    csum_pkg::csum_rec_t    rec_out;
    logic                   rec_empty;
    logic [RESULT_LW-1:0]   rec_level;

    logic                   acc_valid;
    csum_pkg::word_t        acc_a;
    csum_pkg::word_t        acc_b;
    csum_pkg::word_t        acc_result;
    logic                   acc_rdy;
    logic [7:0]             kernel_size;

    assign in_ready = !sample_full;

    sample_fifo #(.payload_t(csum_pkg::word_t), .DEPTH(SAMPLE_DEPTH)) i_sample_fifo (
        .clk(clk), .rst(rst),
        .push(in_valid && in_ready), .push_data(in_data), .full(sample_full),
        .pop(sample_pop), .pop_data(sample_data), .empty(sample_empty),
        .level(sample_level)
    );

    sample_fifo #(.payload_t(csum_pkg::csum_rec_t), .DEPTH(RESULT_DEPTH)) i_result_fifo (
        .clk(clk), .rst(rst),
        .push(rec_push), .push_data(rec_in), .full(rec_full),
        .pop(rec_pop), .pop_data(rec_out), .empty(rec_empty),
        .level(rec_level)
    );

    accum_pipe i_accum_pipe (
        .clk(clk), .rst(rst),
        .op_valid(acc_valid), .operand_a(acc_a), .operand_b(acc_b),
        .op_accept(), .result(acc_result), .result_rdy(acc_rdy)
    );

    csum_engine i_csum_engine (
        .clk(clk), .rst(rst), .kernel_size(kernel_size),
        .sample_data(sample_data), .sample_empty(sample_empty), .sample_pop(sample_pop),
        .acc_valid(acc_valid), .acc_a(acc_a), .acc_b(acc_b),
        .acc_result(acc_result), .acc_rdy(acc_rdy),
        .rec_full(rec_full), .rec_push(rec_push), .rec_data(rec_in)
    );

    csum_apb_regs i_csum_apb_regs (
        .clk(clk), .rst(rst), .apb_req(apb_req), .apb_rsp(apb_rsp),
        .kernel_size(kernel_size),
        .sample_level(8'(sample_level)), .rec_level(8'(rec_level)),  // widen to 8 bits
        .rec_data(rec_out), .rec_empty(rec_empty), .rec_pop(rec_pop)
    );

endmodule

`default_nettype wire

//--- tb/csum_tb.sv
`timescale 1ns/1ps
`default_nettype none

module csum_tb;

    localparam int RESULT_DEPTH = 4;
    localparam int CYCLE_LIMIT  = 20000;  // ~60 samples, 4 cycles each, plus polling

    logic                clk;
    logic                rst;
    logic                in_valid;
    csum_pkg::word_t     in_data;
    logic                in_ready;
    csum_pkg::apb_req_t  apb_req;
    csum_pkg::apb_rsp_t  apb_rsp;

    int                  errors;
    int                  cycles;
    integer              seed;
    logic [7:0]          seq_exp;
    csum_pkg::word_t     blk_q[$];  // samples of the next block
    csum_pkg::csum_rec_t exp_q[$];  // records still to be read

    csum_top #(.SAMPLE_DEPTH(16), .RESULT_DEPTH(RESULT_DEPTH)) i_csum_top (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_data(in_data), .in_ready(in_ready),
        .apb_req(apb_req), .apb_rsp(apb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////
    task automatic check_rec(input string name, input csum_pkg::csum_rec_t exp,
                             input csum_pkg::csum_rec_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected %h, got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            $display("FAILED %s: expected %h, got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s: expected pslverr %b, got %b", name, exp, act);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////
    // bus drivers, entered 2 ns after a rising edge
    //////////////////////////////////////////////////
    task automatic apb_access(input logic wr, input logic [3:0] addr,
                              input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        apb_req.psel    = 1'b1;  // setup phase
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #2;
        apb_req.penable = 1'b1;
        @(negedge clk);  // response settled mid access phase
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        if (apb_rsp.pready !== 1'b1) begin
            $display("pready not high in the access phase at address %h", addr);
            errors++;
        end
        @(posedge clk);
        #2;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] wdata,
                             output logic err);
        logic [31:0] unused;
        apb_access(1'b1, addr, wdata, unused, err);
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] rdata,
                            output logic err);
        apb_access(1'b0, addr, 32'h0, rdata, err);
    endtask

    task automatic send_sample(input csum_pkg::word_t data);
        logic rdy;
        in_valid = 1'b1;
        in_data  = data;
        do begin
            @(negedge clk);
            rdy = in_ready;
            @(posedge clk);
        end while (!rdy);
        #2;
        in_valid = 1'b0;
    endtask

    // sends blk_q as one block and queues the record it should produce
    task automatic send_queued(input logic [7:0] kern);
        csum_pkg::csum_rec_t rec;
        csum_pkg::word_t     sum;
        sum = '0;
        while (blk_q.size() > 0) begin
            sum = sum + blk_q[0];  // wraps modulo 2^16
            send_sample(blk_q.pop_front());
        end
        rec.seq    = seq_exp;
        rec.kernel = kern;
        rec.sum    = sum;
        exp_q.push_back(rec);
        seq_exp++;
    endtask

    task automatic send_random_block(input logic [7:0] kern);
        for (int i = 0; i < int'(kern); i++) blk_q.push_back(16'($random(seed)));
        send_queued(kern);
    endtask

    task automatic expect_results(input string name, input int n);
        logic [31:0] status;
        logic [31:0] data;
        logic        err;
        for (int i = 0; i < n; i++) begin
            do begin
                apb_read(csum_pkg::ADDR_STATUS, status, err);
            end while (status[15:8] == 8'd0);
            apb_read(csum_pkg::ADDR_RESULT, data, err);
            check_err(name, 1'b0, err);
            check_rec(name, exp_q.pop_front(), csum_pkg::csum_rec_t'(data));
        end
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////
    task automatic test_reset_defaults();
        logic [31:0] data;
        logic        err;
        apb_read(csum_pkg::ADDR_CTRL, data, err);
        check_word("reset ctrl", 32'h4, data);
        check_err("reset ctrl", 1'b0, err);
        apb_read(csum_pkg::ADDR_STATUS, data, err);
        check_word("reset status", 32'h0, data);
        apb_read(csum_pkg::ADDR_RESULT, data, err);
        check_word("reset result", 32'h0, data);
        check_err("reset result", 1'b1, err);
        if (in_ready !== 1'b1) begin
            $display("in_ready is not high after reset");
            errors++;
        end
    endtask

    task automatic test_single_block();
        logic [31:0] data;
        logic        err;
        blk_q = '{16'hfff0, 16'h0020, 16'h8000, 16'h9001};  // total exceeds 0xffff
        send_queued(8'd4);
        expect_results("single block", 1);
        apb_read(csum_pkg::ADDR_STATUS, data, err);
        check_word("single block status", 32'h0, data);
    endtask

    task automatic test_kernel_change();
        logic err;
        apb_write(csum_pkg::ADDR_CTRL, 32'd7, err);
        check_err("kernel 7 write", 1'b0, err);
        send_random_block(8'd7);
        send_random_block(8'd7);
        expect_results("kernel 7", 2);
        apb_write(csum_pkg::ADDR_CTRL, 32'd1, err);
        for (int i = 0; i < 3; i++) send_random_block(8'd1);
        expect_results("kernel 1", 3);
    endtask

    task automatic test_back_pressure();
        logic [31:0] data;
        logic        err;
        int          n;
        apb_write(csum_pkg::ADDR_CTRL, 32'd2, err);
        // 4 records stored, 1 held in the engine, 16 samples buffered
        for (int i = 0; i < 13; i++) send_random_block(8'd2);
        n = 0;
        while (in_ready && n < 200) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (in_ready) begin
            $display("in_ready stayed high with both FIFOs full");
            errors++;
        end
        apb_read(csum_pkg::ADDR_STATUS, data, err);
        check_word("back-pressure status", {16'h0, 8'(RESULT_DEPTH), 8'd16}, data);
        expect_results("back-pressure drain", 13);
        apb_read(csum_pkg::ADDR_STATUS, data, err);
        check_word("drained status", 32'h0, data);
    endtask

    task automatic test_error_responses();
        logic [31:0] data;
        logic        err;
        apb_write(csum_pkg::ADDR_CTRL, 32'd0, err);
        check_err("ctrl write 0", 1'b1, err);
        apb_read(csum_pkg::ADDR_CTRL, data, err);
        check_word("ctrl kept", 32'd2, data);
        apb_write(csum_pkg::ADDR_STATUS, 32'h1234, err);
        check_err("status write", 1'b1, err);
        apb_read(4'hc, data, err);
        check_err("unmapped read", 1'b1, err);
        apb_read(csum_pkg::ADDR_STATUS, data, err);
        check_word("status after errors", 32'h0, data);
    endtask

    initial begin
        errors   = 0;
        cycles   = 0;
        seed     = 32'h6f54;
        seq_exp  = 8'd0;
        rst      = 1'b1;
        in_valid = 1'b0;
        in_data  = '0;
        apb_req  = '0;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        test_reset_defaults();
        test_single_block();
        test_kernel_change();
        test_back_pressure();
        test_error_responses();

        $display("%0d errors", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- csum_sys.f
logic/csum_pkg.sv
logic/sample_fifo.sv
logic/accum_pipe.sv
logic/csum_engine.sv
logic/csum_apb_regs.sv
logic/csum_top.sv
tb/csum_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the checksum testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module csum_tb -Mdir obj_dir -f csum_sys.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vcsum_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Done: no errors$" "$LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
